//--- include/mux_link_consts.svh
`ifndef MUX_LINK_CONSTS_SVH
`define MUX_LINK_CONSTS_SVH

//////////////////////////////
// Link word format
//////////////////////////////

// Width of one deserialized word
`define MUX_WORD_W 8

// First training word, sent while hunting
`define MUX_TRAIN_IDLE 8'h01

// Second training word, sent once a pattern is seen
`define MUX_TRAIN_ARM 8'h81

// Switch bits carried below the liveness bit
`define SW_COUNT 7

`endif

//--- project.f
+incdir+include
src/mux_link_pkg.sv
src/board_io_pkg.sv
src/button_sync.sv
src/link_trainer.sv
src/mux_link_top.sv
tb/mux_link_properties.sv
tb/tb_mux_link.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mux link testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timing -j 0 --timescale 1ns/100ps \
	--top-module tb_mux_link -f project.f -Mdir "$BUILD_DIR" -o sim_mux_link
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./"$BUILD_DIR"/sim_mux_link > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- src/board_io_pkg.sv
`default_nettype none

`include "mux_link_consts.svh"

// Types seen on the board side
package board_io_pkg;

	// Slide switches forwarded over the link
	typedef logic [`SW_COUNT-1:0] switch_vec_t;

	// LED bank
	// Top LED for the lock flag, rest mirror the received word
	typedef logic [`SW_COUNT:0] led_vec_t;

endpackage

`default_nettype wire

//--- src/button_sync.sv
`default_nettype none

// Retrain button synchronizer
// Falling edge of the synchronized level gives a single pulse
module button_sync (
	input  logic GMII_GTX_CLK_int,
	input  logic dsp_rst,
	input  logic btn_i,
	output logic fall_o
);

	//////////////////////////////
	// Synchronizer chain
	//////////////////////////////

	// First stage may go metastable
	logic meta_q;
	// Second stage is the clean level
	logic sync_q;
	// Previous clean level for edge detection
	logic prev_q;

	// Ones on reset
	// A button already held low gives no pulse
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			meta_q <= 1'b1;
			sync_q <= 1'b1;
			prev_q <= 1'b1;
		end else begin
			meta_q <= btn_i;
			sync_q <= meta_q;
			prev_q <= sync_q;
		end
	end

	//////////////////////////////
	// Edge detect
	//////////////////////////////

	// High for one cycle on 1 to 0
	assign fall_o = prev_q & ~sync_q;

endmodule

`default_nettype wire

//--- src/link_trainer.sv
`default_nettype none

`include "mux_link_consts.svh"

// Word alignment trainer for the parallel link
// Sends training words and requests bitslips until the partner echoes them,
// then sends switches with a toggling liveness bit and watches the partner's
module link_trainer (
	input  logic                       GMII_GTX_CLK_int,
	input  logic                       dsp_rst,
	input  logic                       retrain_i,
	input  mux_link_pkg::link_word_t   rx_word_i,
	input  board_io_pkg::switch_vec_t  payload_i,
	output mux_link_pkg::link_word_t   tx_word_o,
	output logic                       bitslip_o,
	output logic                       locked_o
);

	//////////////////////////////
	// Declarations
	//////////////////////////////

	// Alignment state
	mux_link_pkg::train_state_e state_q;
	// Training word currently sent
	mux_link_pkg::link_word_t   pattern_q;

	// Bitslip request and its one-cycle delayed copy
	logic bitslip_q;
	logic bitslip_dly_q;

	// Local liveness bit
	logic live_q;

	// Partner liveness monitor
	logic mon_expect_q;
	logic mon_valid_q;

	// Reset or retrain
	logic clr;

	// Received word decode
	logic rx_is_idle;
	logic rx_is_arm;
	logic rx_is_pattern;
	logic rx_live;

	// Bitslip wanted this cycle
	logic slip_want;

	// Aligned transmit word
	mux_link_pkg::tx_frame_t tx_frame;

	//////////////////////////////
	// Decode
	//////////////////////////////

	// Retrain acts as a second synchronous reset
	assign clr = dsp_rst | retrain_i;

	assign rx_is_idle    = (rx_word_i == `MUX_TRAIN_IDLE);
	assign rx_is_arm     = (rx_word_i == `MUX_TRAIN_ARM);
	assign rx_is_pattern = rx_is_idle | rx_is_arm;

	// Partner liveness sits in the top bit
	assign rx_live = rx_word_i[`MUX_WORD_W-1];

	assign locked_o = (state_q == mux_link_pkg::LOCKED);

	// Garbage on the link while training
	assign slip_want = ~locked_o & ~rx_is_pattern;

	//////////////////////////////
	// Liveness toggle
	//////////////////////////////

	// Free running, first edge after reset gives 1
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (clr) begin
			live_q <= 1'b0;
		end else begin
			live_q <= ~live_q;
		end
	end

	//////////////////////////////
	// Bitslip pacing
	//////////////////////////////

	// One-cycle pulse, then two quiet cycles
	// Lets the deserializer settle before the next slip is judged
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (clr) begin
			bitslip_q     <= 1'b0;
			bitslip_dly_q <= 1'b0;
		end else begin
			bitslip_q     <= slip_want & ~bitslip_q & ~bitslip_dly_q;
			bitslip_dly_q <= bitslip_q;
		end
	end

	assign bitslip_o = bitslip_q;

	//////////////////////////////
	// Training FSM and monitor
	//////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (clr) begin
			state_q      <= mux_link_pkg::HUNT;
			pattern_q    <= `MUX_TRAIN_IDLE;
			mon_expect_q <= 1'b0;
			mon_valid_q  <= 1'b0;
		end else begin
			case (state_q)
				mux_link_pkg::HUNT,
				mux_link_pkg::ARMED: begin
					if (!rx_is_pattern) begin
						// Misaligned, start over from the idle word
						state_q     <= mux_link_pkg::HUNT;
						pattern_q   <= `MUX_TRAIN_IDLE;
						mon_valid_q <= 1'b0;
					end else begin
						pattern_q <= `MUX_TRAIN_ARM;
						// Partner echoes 0x81 after we already sent it
						if (rx_is_arm && state_q == mux_link_pkg::ARMED) begin
							state_q <= mux_link_pkg::LOCKED;
						end else begin
							state_q <= mux_link_pkg::ARMED;
						end
					end
				end
				mux_link_pkg::LOCKED: begin
					if (mon_valid_q) begin
						if (rx_live == mon_expect_q) begin
							// Partner still alive
							mon_expect_q <= ~rx_live;
						end else begin
							// Stuck bit, alignment lost
							// Pattern stays 0x81 until garbage shows up
							state_q     <= mux_link_pkg::ARMED;
							mon_valid_q <= 1'b0;
						end
					end else if (!rx_is_arm) begin
						// First payload word seeds the monitor
						mon_expect_q <= ~rx_live;
						mon_valid_q  <= 1'b1;
					end
				end
				default: begin
					state_q <= mux_link_pkg::HUNT;
				end
			endcase
		end
	end

	//////////////////////////////
	// Transmit word
	//////////////////////////

	assign tx_frame.live    = live_q;
	assign tx_frame.payload = payload_i;

	// Frame when aligned, training word otherwise
	assign tx_word_o = locked_o ? mux_link_pkg::link_word_t'(tx_frame) : pattern_q;

endmodule

`default_nettype wire

//--- src/mux_link_pkg.sv
`default_nettype none

`include "mux_link_consts.svh"

// Types seen on the parallel link side
package mux_link_pkg;

	// One deserialized word, either direction
	typedef logic [`MUX_WORD_W-1:0] link_word_t;

	// Alignment progress
	// HUNT when no pattern has been seen yet
	// ARMED while 0x81 goes out and 0x81 is awaited
	// LOCKED once the partner answered 0x81 twice
	typedef enum logic [1:0] {
		HUNT   = 2'd0,
		ARMED  = 2'd1,
		LOCKED = 2'd2
	} train_state_e;

	// Word sent once aligned
	// Liveness bit on top, switch payload below
	typedef struct packed {
		logic                 live;
		logic [`SW_COUNT-1:0] payload;
	} tx_frame_t;

endpackage

`default_nettype wire

//--- src/mux_link_top.sv
`default_nettype none

`include "mux_link_consts.svh"

// Link trainer with the board controls around it
module mux_link_top (
	input  logic                       GMII_GTX_CLK_int,
	input  logic                       dsp_rst,
	input  mux_link_pkg::link_word_t   mux_in_i,
	input  board_io_pkg::switch_vec_t  sw_i,
	input  logic                       btn_retrain_i,
	output mux_link_pkg::link_word_t   mux_out_o,
	output logic                       bitslip_o,
	output board_io_pkg::led_vec_t     leds_o
);

	// One-cycle retrain request from the button
	logic retrain_pulse;
	// Aligned flag from the trainer
	logic locked;

	//////////////////////////////
	// Retrain button
	//////////////////////////////

	// Active low button, press is the falling edge
	button_sync u_btn_sync (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.btn_i            (btn_retrain_i),
		.fall_o           (retrain_pulse)
	);

	//////////////////////////////
	// Trainer
	//////////////////////////////

	link_trainer u_trainer (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.retrain_i        (retrain_pulse),
		.rx_word_i        (mux_in_i),
		.payload_i        (sw_i),
		.tx_word_o        (mux_out_o),
		.bitslip_o        (bitslip_o),
		.locked_o         (locked)
	);

	//////////////////////////////
	// LEDs
	//////////////////////////////

	// Lock flag on top, raw received bits below
	assign leds_o = {locked, mux_in_i[`SW_COUNT-1:0]};

endmodule

`default_nettype wire

//--- tb/mux_link_golden.txt
// hex columns: mux_in sw btn (stimulus), mux_out bitslip leds (expected)
// sw ff means a random switch value, used only on unlocked cycles
3c ff 1 01 0 3c
a5 ff 1 01 1 25
5a ff 1 01 0 5a
00 ff 1 01 0 00
ff ff 1 01 1 7f
c3 ff 1 01 0 43
10 ff 1 01 0 10
01 ff 1 01 1 01
01 ff 1 81 0 01
81 ff 1 81 0 01
81 2a 1 2a 0 81
55 55 1 d5 0 d5
b3 0f 1 0f 0 b3
4c 70 1 f0 0 cc
9e 01 1 01 0 9e
27 7f 1 ff 0 a7
31 12 1 12 0 b1
6d ff 1 81 0 6d
01 ff 1 01 1 01
81 ff 1 81 0 01
81 33 1 33 0 81
5e 44 0 c4 0 de
a0 08 0 08 0 a0
1b 19 0 99 0 9b
81 ff 0 01 0 01
81 ff 1 81 0 01
7a 66 1 66 0 fa
c8 2d 1 ad 0 c8
0f 50 1 50 0 8f
90 03 1 83 0 90

//--- tb/mux_link_properties.sv
`default_nettype none

`include "mux_link_consts.svh"

// Protocol checks on the link top level
module mux_link_properties (
	input logic                     GMII_GTX_CLK_int,
	input logic                     dsp_rst,
	input mux_link_pkg::link_word_t mux_out_o,
	input logic                     bitslip_o,
	input board_io_pkg::led_vec_t   leds_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// Number of failed properties so far
	int unsigned fail_count = 0;

	//////////////////////////////
	// Bitslip
	//////////////////////////////

	// Single-cycle pulse that never repeats on the next cycle
	a_bitslip_single: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		bitslip_o |=> !bitslip_o
	) else begin
		fail_count++;
		$error("bitslip_o high on two consecutive cycles");
	end

	// Quiet right after reset
	a_bitslip_reset: assert property (
		@(posedge GMII_GTX_CLK_int)
		dsp_rst |=> !bitslip_o
	) else begin
		fail_count++;
		$error("bitslip_o high in the cycle after reset");
	end

	//////////////////////////////
	// Training words
	//////////////////////////////

	// Lock LED off means a training word goes out
	a_unlocked_pattern: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		!leds_o[`MUX_WORD_W-1] |->
			(mux_out_o == `MUX_TRAIN_IDLE || mux_out_o == `MUX_TRAIN_ARM)
	) else begin
		fail_count++;
		$error("mux_out_o not a training word while unlocked");
	end

endmodule

bind mux_link_top mux_link_properties i_props (
	.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
	.dsp_rst          (dsp_rst),
	.mux_out_o        (mux_out_o),
	.bitslip_o        (bitslip_o),
	.leds_o           (leds_o)
);

`default_nettype wire

//--- tb/tb_mux_link.sv
`default_nettype none

`include "mux_link_consts.svh"

module tb_mux_link;

	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////
	// Run constants
	//////////////////////////////

	localparam string       GOLDEN_PATH     = "tb/mux_link_golden.txt";
	localparam int          N_VECTORS       = 30;
	localparam int          RESET_CYCLES    = 3;
	localparam int          WATCHDOG_CYCLES = 500;
	localparam logic [31:0] SEED            = 32'h279dd93c;
	// Switch field value asking for a random switch word
	localparam logic [7:0]  SW_RANDOM       = 8'hff;

	// One line of the golden file
	typedef struct packed {
		mux_link_pkg::link_word_t mux_in;
		logic [7:0]               sw;
		logic                     btn;
		mux_link_pkg::link_word_t mux_out;
		logic                     bitslip;
		board_io_pkg::led_vec_t   leds;
	} golden_vec_t;

	//////////////////////////////
	// DUT signals
	//////////////////////////////

	logic                      GMII_GTX_CLK_int;
	logic                      dsp_rst;
	mux_link_pkg::link_word_t  mux_in;
	board_io_pkg::switch_vec_t sw;
	logic                      btn_retrain;
	mux_link_pkg::link_word_t  mux_out;
	logic                      bitslip;
	board_io_pkg::led_vec_t    leds;

	// Vectors from the golden file
	golden_vec_t vectors[$];

	mux_link_top i_dut (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.mux_in_i         (mux_in),
		.sw_i             (sw),
		.btn_retrain_i    (btn_retrain),
		.mux_out_o        (mux_out),
		.bitslip_o        (bitslip),
		.leds_o           (leds)
	);

	// 4 ns link clock
	initial begin
		GMII_GTX_CLK_int = 1'b0;
		forever begin
			#2 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
		end
	end

	//////////////////////////////
	// Failure reporting
	//////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic report_mismatch(input string sig, input logic [7:0] exp_val,
			input logic [7:0] got_val, input int idx);
		$display("[ERROR] time %0t: %s expected 0x%h, got 0x%h (vector %0d)",
			$time, sig, exp_val, got_val, idx);
		$display("Test FAILED");
		$fatal(1, "output mismatch");
	endtask

	//////////////////////////////
	// Golden file
	//////////////////////////////

	task automatic load_golden();
		int          fd;
		int          got;
		string       text;
		logic [7:0]  f_in;
		logic [7:0]  f_sw;
		logic        f_btn;
		logic [7:0]  f_out;
		logic        f_bs;
		logic [7:0]  f_leds;
		golden_vec_t vec;
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0) begin
			fail_run($sformatf("Cannot open the golden file %s", GOLDEN_PATH));
		end
		while (!$feof(fd)) begin
			if ($fgets(text, fd) == 0) begin
				break;
			end
			// Comments and blank lines
			if (text.len() < 2 || text.getc(0) == "/") begin
				continue;
			end
			got = $sscanf(text, "%h %h %h %h %h %h", f_in, f_sw, f_btn, f_out, f_bs, f_leds);
			if (got != 6) begin
				fail_run($sformatf("Golden file line cannot be parsed: %s", text));
			end
			vec.mux_in  = f_in;
			vec.sw      = f_sw;
			vec.btn     = f_btn;
			vec.mux_out = f_out;
			vec.bitslip = f_bs;
			vec.leds    = f_leds;
			vectors.push_back(vec);
		end
		$fclose(fd);
		if (vectors.size() < N_VECTORS) begin
			fail_run($sformatf("Golden file holds only %0d vectors, %0d needed",
				vectors.size(), N_VECTORS));
		end
	endtask

	//////////////////////////////
	// Drive and compare
	//////////////////////////////

	// Called right after a rising edge
	task automatic drive_vector(input golden_vec_t vec);
		logic [31:0] rnd;
		rnd = $urandom();
		mux_in      <= vec.mux_in;
		btn_retrain <= vec.btn;
		// Random switches only where the link is not locked
		if (vec.sw == SW_RANDOM) begin
			sw <= rnd[`SW_COUNT-1:0];
		end else begin
			sw <= vec.sw[`SW_COUNT-1:0];
		end
	endtask

	// Called on the falling edge once outputs have settled
	task automatic check_vector(input golden_vec_t vec, input int idx);
		assert (mux_out == vec.mux_out)
		else report_mismatch("mux_out_o", vec.mux_out, mux_out, idx);
		assert (bitslip == vec.bitslip)
		else report_mismatch("bitslip_o", {7'b0, vec.bitslip}, {7'b0, bitslip}, idx);
		assert (leds == vec.leds)
		else report_mismatch("leds_o", vec.leds, leds, idx);
		// Low LEDs mirror the received word
		assert (leds[`SW_COUNT-1:0] == mux_in[`SW_COUNT-1:0])
		else report_mismatch("leds_o[6:0]", {1'b0, mux_in[`SW_COUNT-1:0]},
			{1'b0, leds[`SW_COUNT-1:0]}, idx);
		// Bound protocol properties up to the last rising edge
		assert (i_dut.i_props.fail_count == 0)
		else fail_run($sformatf("A bound protocol property failed before vector %0d", idx));
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin : stimulus
		int idx;
		void'($urandom(SEED));
		dsp_rst     = 1'b1;
		mux_in      = '0;
		sw          = '0;
		btn_retrain = 1'b1;
		load_golden();
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge GMII_GTX_CLK_int);
		end
		// Reset released and first vector driven on the same edge
		dsp_rst <= 1'b0;
		for (idx = 0; idx < vectors.size(); idx++) begin
			drive_vector(vectors[idx]);
			@(negedge GMII_GTX_CLK_int);
			check_vector(vectors[idx], idx);
			@(posedge GMII_GTX_CLK_int);
		end
		// Properties of the final rising edge
		@(negedge GMII_GTX_CLK_int);
		if (i_dut.i_props.fail_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("%0d bound protocol property failures", i_dut.i_props.fail_count);
			$display("Test FAILED");
			$fatal(1, "property failures");
		end
	end

	// Hard bound on the run
	initial begin : watchdog
		for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
			@(posedge GMII_GTX_CLK_int);
		end
		$display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
